//--- rtl/obj_macros.svh
`ifndef OBJ_MACROS_SVH
`define OBJ_MACROS_SVH

`default_nettype none

// frame table depth, 1024 entries
`define OBJ_TABLE_AW 10

// pixel positions and render line
`define OBJ_HW 9

// line buffer locations
`define OBJ_LINE_W 512

// attr value that closes the table early
`define OBJ_END_ATTR 16'hff00

`default_nettype wire

`endif

//--- rtl/obj_pkg.sv
`include "obj_macros.svh"
`default_nettype none

package obj_pkg;

    // frame table word, x/y/code/attr as the cpu sees them
    typedef struct packed {
        logic [15:0] x;     // [15:13] prio, [8:0] pos
        logic [15:0] y;     // [15] end, [14:13] bank, [8:0] pos
        logic [15:0] code;
        logic [15:0] attr;  // [15:12] m, [11:8] n, [6] vflip, [5] hflip, [4:0] pal
    } obj_entry_t;

    // one tile for the renderer
    typedef struct packed {
        logic [15:0]        code;   // final tile code
        logic [3:0]         vsub;   // row inside the tile
        logic               hflip;
        logic [4:0]         pal;
        logic [`OBJ_HW-1:0] hpos;
        logic [2:0]         prio;
        logic [5:0]         spare;
    } draw_cmd_t;

    // line buffer word
    typedef struct packed {
        logic [2:0] prio;
        logic [4:0] pal;
        logic [3:0] color;  // 15 = transparent
    } obj_pix_t;

    typedef enum logic [2:0] {
        scan_idle,
        scan_fetch,      // table read in flight
        scan_zone,       // waiting on tile match
        scan_wait_draw,  // renderer busy
        scan_next_tile
    } scan_st_e;

    typedef enum logic [1:0] {
        draw_idle,
        draw_rom_wait,
        draw_write
    } draw_st_e;

endpackage

`default_nettype wire

//--- rtl/obj_table.sv
`include "obj_macros.svh"
`default_nettype none

// frame table, cpu writes on one side, scanner reads on the other
module obj_table
    import obj_pkg::*;
(
    input  wire                      clk,

    // cpu side
    input  wire                      tbl_we,
    input  wire [`OBJ_TABLE_AW-1:0]  tbl_addr,
    input  wire obj_entry_t          tbl_data,

    // scanner side
    input  wire [`OBJ_TABLE_AW-1:0]  table_addr,
    output obj_entry_t               table_entry
);

    obj_entry_t mem [0:(1<<`OBJ_TABLE_AW)-1];

    always_ff @(posedge clk) begin
        if (tbl_we) begin
            mem[tbl_addr] <= tbl_data;
        end
    end

    // registered read, entry shows up one cycle after the address
    always_ff @(posedge clk) begin
        table_entry <= mem[table_addr];
    end

endmodule

`default_nettype wire

//--- rtl/obj_tile_match.sv
`include "obj_macros.svh"
`default_nettype none

// zone test and tile code, two register stages from entry/n to outputs
module obj_tile_match
    import obj_pkg::*;
(
    input  wire                clk,
    input  wire obj_entry_t    entry,
    input  wire [`OBJ_HW-1:0]  vrenderf,  // render line, already flipped
    input  wire [3:0]          n,         // tile column
    output logic               inzone,
    output logic [3:0]         vsub,
    output logic [15:0]        code_mn
);

    // stage 1 registers
    logic [`OBJ_HW-1:0] dy_q;     // line offset inside the object
    logic [3:0]         m_q;      // object height in tiles, minus one
    logic [3:0]         n_q;
    logic               vflip_q;
    logic [15:0]        code_q;

    logic [3:0]         row;      // tile row within the object
    logic [3:0]         row_f;    // same, mirrored for vflip

    always_ff @(posedge clk) begin
        dy_q    <= vrenderf - entry.y[`OBJ_HW-1:0];  // wraps, negatives land high
        m_q     <= entry.attr[15:12];
        n_q     <= n;
        vflip_q <= entry.attr[6];
        code_q  <= entry.code;
    end

    assign row   = dy_q[7:4];
    assign row_f = vflip_q ? (m_q - row) : row;  // bottom tile first

    // stage 2
    always_ff @(posedge clk) begin
        inzone  <= dy_q[`OBJ_HW-1:4] <= {1'b0, m_q};  // dy < 16*(m+1)
        vsub    <= dy_q[3:0] ^ {4{vflip_q}};           // 15-dy under vflip
        // tiles laid out 16 per row in rom
        code_mn <= code_q + {12'd0, n_q} + {8'd0, row_f, 4'd0};
    end

endmodule

`default_nettype wire

//--- rtl/obj_scan.sv
`include "obj_macros.svh"
`default_nettype none

// walks the frame table for one line, expands objects into tile commands
module obj_scan
    import obj_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      flip,
    input  wire [`OBJ_HW-1:0]        vrender,     // one line ahead of display
    input  wire                      start,

    // frame table
    output logic [`OBJ_TABLE_AW-1:0] table_addr,
    input  wire obj_entry_t          table_entry,

    // renderer
    output logic                     dr_start,
    output draw_cmd_t                dr_cmd,
    input  wire                      dr_idle,

    output logic                     done
);

    scan_st_e           st;
    logic               start_q;
    logic               start_edge;
    logic [`OBJ_HW-1:0] vrenderf;
    logic [3:0]         n;          // tile counter
    logic [3:0]         npos;       // x slot of the tile, reversed under hflip
    logic [1:0]         wait_cnt;   // tile match latency
    logic               pend_done;  // table finished, renderer may still draw

    logic               inzone;
    logic [3:0]         vsub;
    logic [15:0]        code_mn;

    logic [3:0]         tile_n;
    logic               hflip;
    logic               tbl_end;
    logic [`OBJ_HW-1:0] eff_x;

    obj_tile_match u_tile_match (
        .clk      (clk),
        .entry    (table_entry),
        .vrenderf (vrenderf),
        .n        (n),
        .inzone   (inzone),
        .vsub     (vsub),
        .code_mn  (code_mn)
    );

    assign start_edge = start & ~start_q;
    assign tile_n     = table_entry.attr[11:8];
    assign hflip      = table_entry.attr[5];
    assign tbl_end    = table_entry.y[15] || (table_entry.attr == `OBJ_END_ATTR);
    // one pixel to the left, as on the original hardware
    assign eff_x      = table_entry.x[`OBJ_HW-1:0] + {1'b0, npos, 4'd0} - 9'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= scan_idle;
            start_q    <= 1'b0;
            table_addr <= '0;
            vrenderf   <= '0;
            n          <= '0;
            npos       <= '0;
            wait_cnt   <= '0;
            pend_done  <= 1'b0;
            dr_start   <= 1'b0;
            done       <= 1'b0;
        end else begin
            start_q  <= start;
            dr_start <= 1'b0;  // strobes
            done     <= 1'b0;
            if (start_edge) begin  // restart wins over any state
                vrenderf   <= vrender ^ {1'b0, {8{flip}}};  // 256-line flip
                table_addr <= '0;
                n          <= '0;
                pend_done  <= 1'b0;
                st         <= scan_fetch;
            end else begin
                case (st)
                    scan_idle: begin
                        if (pend_done && dr_idle) begin
                            done      <= 1'b1;
                            pend_done <= 1'b0;
                        end
                    end
                    scan_fetch: begin
                        wait_cnt <= 2'd2;
                        st       <= scan_zone;
                    end
                    scan_zone: begin
                        if (tbl_end) begin
                            pend_done <= 1'b1;
                            st        <= scan_idle;
                        end else if (wait_cnt != 2'd0) begin
                            wait_cnt <= wait_cnt - 2'd1;
                        end else if (!inzone) begin  // skip entry
                            n <= '0;
                            if (&table_addr) begin  // last slot
                                pend_done <= 1'b1;
                                st        <= scan_idle;
                            end else begin
                                table_addr <= table_addr + 1'b1;
                                st         <= scan_fetch;
                            end
                        end else begin
                            if (n == 4'd0) begin
                                npos <= hflip ? tile_n : 4'd0;
                            end
                            st <= scan_wait_draw;
                        end
                    end
                    scan_wait_draw: begin
                        if (dr_idle) begin
                            dr_start <= 1'b1;
                            st       <= scan_next_tile;
                        end
                    end
                    scan_next_tile: begin
                        if (n == tile_n) begin  // object done, look up the next one
                            n <= '0;
                            if (&table_addr) begin
                                pend_done <= 1'b1;
                                st        <= scan_idle;
                            end else begin
                                table_addr <= table_addr + 1'b1;
                                st         <= scan_fetch;
                            end
                        end else begin
                            n        <= n + 4'd1;
                            npos     <= hflip ? npos - 4'd1 : npos + 4'd1;
                            wait_cnt <= 2'd2;  // new n through tile match
                            st       <= scan_zone;
                        end
                    end
                    default: st <= scan_idle;
                endcase
            end
        end
    end

    // command payload, taken with the dr_start edge
    always_ff @(posedge clk) begin
        if (st == scan_wait_draw && dr_idle) begin
            dr_cmd <= '{code:  code_mn,
                        vsub:  vsub,
                        hflip: hflip,
                        pal:   table_entry.attr[4:0],
                        hpos:  eff_x,
                        prio:  table_entry.x[15:13],
                        spare: 6'd0};
        end
    end

endmodule

`default_nettype wire

//--- rtl/obj_draw.sv
`include "obj_macros.svh"
`default_nettype none

// tile renderer, one rom row then 16 pixel writes
module obj_draw
    import obj_pkg::*;
(
    input  wire                clk,
    input  wire                rst,

    // from scanner
    input  wire                dr_start,
    input  wire draw_cmd_t     dr_cmd,
    output logic               dr_idle,

    // tile rom
    output logic [19:0]        rom_addr,
    output logic               rom_cs,
    input  wire                rom_ok,
    input  wire [63:0]         rom_data,

    // line buffer
    output logic               buf_we,
    output logic [`OBJ_HW-1:0] buf_addr,
    output obj_pix_t           buf_pix
);

    draw_st_e    st;
    draw_cmd_t   cmd;      // latched command
    logic [63:0] row;      // 16 nibbles
    logic [3:0]  k;        // pixel counter
    logic [3:0]  nib_sel;

    assign dr_idle  = (st == draw_idle);
    assign buf_we   = (st == draw_write);
    assign nib_sel  = cmd.hflip ? ~k : k;  // 15-k when mirrored
    assign buf_addr = cmd.hpos + {{(`OBJ_HW-4){1'b0}}, k};  // wraps at line end
    assign buf_pix  = '{prio:  cmd.prio,
                        pal:   cmd.pal,
                        color: row[{nib_sel, 2'b00} +: 4]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st     <= draw_idle;
            rom_cs <= 1'b0;
            k      <= '0;
        end else begin
            case (st)
                draw_idle: begin
                    if (dr_start) begin
                        rom_cs <= 1'b1;  // held until rom_ok
                        st     <= draw_rom_wait;
                    end
                end
                draw_rom_wait: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        k      <= '0;
                        st     <= draw_write;
                    end
                end
                draw_write: begin
                    k <= k + 4'd1;
                    if (k == 4'd15) begin  // last pixel this cycle
                        st <= draw_idle;
                    end
                end
                default: st <= draw_idle;
            endcase
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (st == draw_idle && dr_start) begin
            cmd      <= dr_cmd;
            rom_addr <= {dr_cmd.code, dr_cmd.vsub};  // row address
        end
        if (st == draw_rom_wait && rom_ok) begin
            row <= rom_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/obj_line_buf.sv
`include "obj_macros.svh"
`default_nettype none

// one line of object pixels, opaque-wins writes, read clears
module obj_line_buf
    import obj_pkg::*;
(
    input  wire                clk,

    // renderer side
    input  wire                buf_we,
    input  wire [`OBJ_HW-1:0]  buf_addr,
    input  wire obj_pix_t      buf_pix,

    // video side
    input  wire                rd_en,
    input  wire [`OBJ_HW-1:0]  rd_addr,
    output obj_pix_t           rd_pix
);

    localparam obj_pix_t pix_clear = '{prio: 3'd0, pal: 5'd0, color: 4'hf};

    obj_pix_t mem [0:`OBJ_LINE_W-1];
    obj_pix_t wr_old;     // current content at the write address
    logic     erase_hit;  // erase on the same location this cycle
    logic     wr_ok;

    assign wr_old    = mem[buf_addr];
    assign erase_hit = rd_en && (rd_addr == buf_addr);
    // earlier objects keep their pixels
    assign wr_ok     = buf_we && (buf_pix.color != 4'hf) && (wr_old.color == 4'hf)
                       && !erase_hit;

    // buffer starts out empty
    initial begin
        for (int i = 0; i < `OBJ_LINE_W; i++) begin
            mem[i] = pix_clear;
        end
    end

    always @(posedge clk) begin
        if (wr_ok) begin
            mem[buf_addr] <= buf_pix;
        end
        if (rd_en) begin
            rd_pix        <= mem[rd_addr];
            mem[rd_addr]  <= pix_clear;  // ready for the next line
        end
    end

endmodule

`default_nettype wire

//--- rtl/obj_top.sv
`include "obj_macros.svh"
`default_nettype none

// object layer, table + scanner + renderer + line buffer
module obj_top
    import obj_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      flip,
    input  wire [`OBJ_HW-1:0]        vrender,
    input  wire                      start,

    // cpu table load
    input  wire                      tbl_we,
    input  wire [`OBJ_TABLE_AW-1:0]  tbl_addr,
    input  wire obj_entry_t          tbl_data,

    // tile rom
    output logic [19:0]              rom_addr,
    output logic                     rom_cs,
    input  wire                      rom_ok,
    input  wire [63:0]               rom_data,

    // video readout
    input  wire                      rd_en,
    input  wire [`OBJ_HW-1:0]        rd_addr,
    output obj_pix_t                 rd_pix,

    output logic                     done
);

    logic [`OBJ_TABLE_AW-1:0] table_addr;
    obj_entry_t               table_entry;
    logic                     dr_start;
    draw_cmd_t                dr_cmd;
    logic                     dr_idle;
    logic                     buf_we;
    logic [`OBJ_HW-1:0]       buf_addr;
    obj_pix_t                 buf_pix;

    obj_table u_table (
        .clk         (clk),
        .tbl_we      (tbl_we),
        .tbl_addr    (tbl_addr),
        .tbl_data    (tbl_data),
        .table_addr  (table_addr),
        .table_entry (table_entry)
    );

    obj_scan u_scan (
        .clk         (clk),
        .rst         (rst),
        .flip        (flip),
        .vrender     (vrender),
        .start       (start),
        .table_addr  (table_addr),
        .table_entry (table_entry),
        .dr_start    (dr_start),
        .dr_cmd      (dr_cmd),
        .dr_idle     (dr_idle),
        .done        (done)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .dr_start (dr_start),
        .dr_cmd   (dr_cmd),
        .dr_idle  (dr_idle),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_pix  (buf_pix)
    );

    obj_line_buf u_line_buf (
        .clk      (clk),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_pix  (buf_pix),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_pix   (rd_pix)
    );

endmodule

`default_nettype wire

//--- dv/obj_properties.sv
`include "obj_macros.svh"
`default_nettype none

// strobe rules between scanner, renderer and rom
module obj_properties (
    input wire        clk,
    input wire        rst,
    input wire        dr_start,
    input wire        dr_idle,
    input wire        rom_cs,
    input wire [19:0] rom_addr,
    input wire        rom_ok,
    input wire        buf_we,
    input wire        done
);
    timeunit 1ns;
    timeprecision 1ps;

    // a command only goes to an idle renderer
    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        dr_start |-> dr_idle)
        else $error("dr_start raised while renderer busy");

    // request held steady until the rom answers
    rom_req_stable: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else $error("rom request changed before rom_ok");

    // one fetched row, 16 pixel writes, then the renderer is free again
    write_burst: assert property (@(posedge clk) disable iff (rst)
        $rose(buf_we) |-> buf_we [*16] ##1 dr_idle)
        else $error("line buffer write burst not 16 pixels");

    done_single: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done longer than one cycle");

endmodule

bind obj_top obj_properties u_props (
    .clk      (clk),
    .rst      (rst),
    .dr_start (dr_start),
    .dr_idle  (dr_idle),
    .rom_cs   (rom_cs),
    .rom_addr (rom_addr),
    .rom_ok   (rom_ok),
    .buf_we   (buf_we),
    .done     (done)
);

`default_nettype wire

//--- dv/obj_checker.sv
`include "obj_macros.svh"
`default_nettype none

// shadows the frame table, predicts the line on start, compares readout
module obj_checker
    import obj_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      tbl_we,
    input  wire [`OBJ_TABLE_AW-1:0]  tbl_addr,
    input  wire obj_entry_t          tbl_data,
    input  wire                      start,
    input  wire                      flip,
    input  wire [`OBJ_HW-1:0]        vrender,
    input  wire                      rom_cs,
    input  wire                      rom_ok,
    input  wire [19:0]               rom_addr,
    input  wire                      done,
    input  wire                      rd_en,
    input  wire [`OBJ_HW-1:0]        rd_addr,
    input  wire obj_pix_t            rd_pix,
    output int                       err_count,
    output int                       opaque_count  // opaque pixels read since start
);
    timeunit 1ns;
    timeprecision 1ps;

    obj_entry_t         shadow [0:(1<<`OBJ_TABLE_AW)-1];
    obj_pix_t           exp_line [0:`OBJ_LINE_W-1];
    logic [19:0]        exp_rom [$];  // row fetches in scan order
    logic               start_q;
    logic               rd_pend;
    logic [`OBJ_HW-1:0] rd_addr_q;

    // expected line, earlier entries keep their opaque pixels
    task automatic build_line(input logic fl, input logic [8:0] vr);
        obj_entry_t  e;
        logic [8:0]  vrf;
        logic [8:0]  dy;
        logic [8:0]  hpos;
        logic [8:0]  pos;
        logic [3:0]  m;
        logic [3:0]  tn;
        logic [3:0]  vsub;
        logic [3:0]  rowf;
        logic [3:0]  npos;
        logic [3:0]  nib;
        logic [3:0]  color;
        logic [15:0] code;
        for (int p = 0; p < `OBJ_LINE_W; p++) begin
            exp_line[p] = '{prio: 3'd0, pal: 5'd0, color: 4'hf};
        end
        exp_rom.delete();
        vrf = vr ^ {1'b0, {8{fl}}};  // flip mirrors the 256-line screen
        for (int i = 0; i < (1 << `OBJ_TABLE_AW); i++) begin
            e = shadow[i];
            if (e.y[15] || e.attr == `OBJ_END_ATTR) break;
            dy = vrf - e.y[8:0];
            m  = e.attr[15:12];
            tn = e.attr[11:8];
            if (dy >= 16 * (m + 1)) continue;  // zone misses the line
            vsub = e.attr[6] ? 4'd15 - dy[3:0] : dy[3:0];
            rowf = e.attr[6] ? m - dy[7:4] : dy[7:4];
            for (int n = 0; n <= tn; n++) begin
                code = e.code + n + 16 * rowf;
                exp_rom.push_back({code, vsub});  // tile code and row
                npos = e.attr[5] ? tn - n : n;
                hpos = e.x[8:0] + 16 * npos - 1;
                for (int k = 0; k < 16; k++) begin
                    nib   = e.attr[5] ? 4'd15 - k : k;
                    color = vsub + nib;  // rom model, low addr bits plus nibble
                    pos   = hpos + k;
                    if (color != 4'hf && exp_line[pos].color == 4'hf) begin
                        exp_line[pos] = '{prio: e.x[15:13], pal: e.attr[4:0], color: color};
                    end
                end
            end
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            err_count    <= 0;
            opaque_count <= 0;
            start_q      <= 1'b0;
            rd_pend      <= 1'b0;
        end else begin
            start_q <= start;
            if (tbl_we) shadow[tbl_addr] = tbl_data;
            if (start && !start_q) begin
                build_line(flip, vrender);
                opaque_count <= 0;
            end
            if (rom_cs && rom_ok) begin  // one row fetch per tile
                if (exp_rom.size() == 0) begin
                    $display("Error: %0t unexpected rom request at rom_addr %h",
                             $time, rom_addr);
                    err_count <= err_count + 1;
                end else begin
                    if (rom_addr !== exp_rom[0]) begin
                        $display("Error: %0t rom_addr expected %h got %h",
                                 $time, exp_rom[0], rom_addr);
                        err_count <= err_count + 1;
                    end
                    void'(exp_rom.pop_front());
                end
            end
            if (done && exp_rom.size() != 0) begin
                $display("Error: %0t done came with %0d tile fetches never made",
                         $time, exp_rom.size());
                err_count <= err_count + 1;
            end
            if (rd_pend) begin  // rd_pix belongs to last cycle's address
                if (rd_pix !== exp_line[rd_addr_q]) begin
                    $display("Error: %0t rd_pix[%0d] expected %h got %h",
                             $time, rd_addr_q, exp_line[rd_addr_q], rd_pix);
                    err_count <= err_count + 1;
                end
                if (rd_pix.color != 4'hf) opaque_count <= opaque_count + 1;
            end
            rd_pend   <= rd_en;
            rd_addr_q <= rd_addr;
        end
    end

endmodule

`default_nettype wire

//--- dv/obj_tb.sv
`include "obj_macros.svh"
`default_nettype none

module obj_tb import obj_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_rows = 9;

    logic               clk;
    logic               rst;
    logic               flip;
    logic [8:0]         vrender;
    logic               start;
    logic               tbl_we;
    logic [9:0]         tbl_addr;
    obj_entry_t         tbl_data;
    logic [19:0]        rom_addr;
    logic               rom_cs;
    logic               rom_ok;
    logic [63:0]        rom_data;
    logic               rd_en;
    logic [8:0]         rd_addr;
    obj_pix_t           rd_pix;
    logic               done;
    int                 chk_errors;
    int                 opaque_count;

    // stimulus table, four entries per line test
    obj_entry_t         test_ent [0:n_rows-1][0:3];
    logic [8:0]         test_vr [0:n_rows-1];
    logic               test_flip [0:n_rows-1];
    int                 test_opaque [0:n_rows-1];  // opaque pixels on the line

    logic [31:0]        lfsr;
    int                 rom_delay;
    int                 tb_errors;
    int                 timeouts;
    logic               got_done;

    obj_top obj_top_i (.*);

    obj_checker u_checker (
        .clk (clk), .rst (rst), .tbl_we (tbl_we), .tbl_addr (tbl_addr),
        .tbl_data (tbl_data), .start (start), .flip (flip), .vrender (vrender),
        .rom_cs (rom_cs), .rom_ok (rom_ok), .rom_addr (rom_addr), .done (done),
        .rd_en (rd_en), .rd_addr (rd_addr), .rd_pix (rd_pix),
        .err_count (chk_errors), .opaque_count (opaque_count)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32,22,2,1
    endfunction

    // rom row, nibble k is the low address nibble plus k
    function automatic logic [63:0] rom_row(input logic [19:0] a);
        logic [63:0] d;
        for (int k = 0; k < 16; k++) d[k*4 +: 4] = a[3:0] + k[3:0];
        return d;
    endfunction

    function automatic obj_entry_t make_obj(input logic [2:0] prio, input logic [8:0] xp,
        input logic [8:0] yp, input logic [15:0] code, input logic [3:0] m,
        input logic [3:0] n, input logic vf, input logic hf, input logic [4:0] pal);
        return '{x: {prio, 4'd0, xp}, y: {7'd0, yp}, code: code,
                 attr: {m, n, 1'b0, vf, hf, pal}};
    endfunction

    function automatic obj_entry_t end_marker();
        return '{x: 16'd0, y: 16'h8000, code: 16'd0, attr: `OBJ_END_ATTR};
    endfunction

    task automatic set_row(input int r, input obj_entry_t e0, input obj_entry_t e1,
        input obj_entry_t e2, input obj_entry_t e3, input logic [8:0] vr,
        input logic fl, input int exp_opaque);
        test_ent[r][0] = e0;
        test_ent[r][1] = e1;
        test_ent[r][2] = e2;
        test_ent[r][3] = e3;
        test_vr[r]     = vr;
        test_flip[r]   = fl;
        test_opaque[r] = exp_opaque;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // rom answers after 1 to 4 cycles, pulses rom_ok for one cycle
    always @(posedge clk) begin
        #1;
        if (rom_ok) begin
            rom_ok    = 1'b0;
            rom_delay = -1;
        end else if (rom_cs) begin
            if (rom_delay < 0) begin
                rom_delay = 1 + lfsr[0];
                lfsr      = lfsr_step(lfsr);
                rom_delay = rom_delay + 2 * lfsr[0];
                lfsr      = lfsr_step(lfsr);
            end
            rom_delay = rom_delay - 1;
            if (rom_delay == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_row(rom_addr);
            end
        end
    end

    initial begin
        clk       = 0;
        rst       = 1;
        flip      = 0;
        vrender   = '0;
        start     = 0;
        tbl_we    = 0;
        tbl_addr  = '0;
        tbl_data  = '0;
        rom_ok    = 0;
        rom_data  = '0;
        rd_en     = 0;
        rd_addr   = '0;
        lfsr      = 32'h1ac4_9c3f;
        rom_delay = -1;
        tb_errors = 0;
        timeouts  = 0;

        // single tile, colors follow vsub 4
        set_row(0, make_obj(3'd1, 9'd50, 9'd96, 16'h0120, 4'd0, 4'd0, 0, 0, 5'd2),
                end_marker(), end_marker(), end_marker(), 9'd100, 0, 15);
        // zone miss, then an object hidden behind the end marker
        set_row(1, make_obj(3'd1, 9'd50, 9'd200, 16'h0040, 4'd0, 4'd0, 0, 0, 5'd1),
                end_marker(), make_obj(3'd1, 9'd80, 9'd96, 16'h0050, 4'd0, 4'd0, 0, 0, 5'd1),
                end_marker(), 9'd100, 0, 0);
        set_row(2, make_obj(3'd4, 9'd200, 9'd90, 16'h0300, 4'd0, 4'd0, 1, 1, 5'd9),
                end_marker(), end_marker(), end_marker(), 9'd100, 0, 15);
        // 3 wide, 2 high, second tile row
        set_row(3, make_obj(3'd2, 9'd300, 9'd80, 16'h0400, 4'd1, 4'd2, 0, 0, 5'd4),
                end_marker(), end_marker(), end_marker(), 9'd100, 0, 45);
        set_row(4, make_obj(3'd2, 9'd300, 9'd80, 16'h0400, 4'd1, 4'd2, 1, 1, 5'd4),
                end_marker(), end_marker(), end_marker(), 9'd100, 0, 45);
        // overlap, later object shows only through the hole of the first
        set_row(5, make_obj(3'd5, 9'd100, 9'd96, 16'h0010, 4'd0, 4'd0, 0, 0, 5'd3),
                make_obj(3'd2, 9'd108, 9'd98, 16'h0020, 4'd0, 4'd0, 0, 0, 5'd7),
                end_marker(), end_marker(), 9'd100, 0, 23);
        // flipped screen, line 100 compares as 155
        set_row(6, make_obj(3'd1, 9'd60, 9'd96, 16'h0060, 4'd0, 4'd0, 0, 0, 5'd1),
                make_obj(3'd6, 9'd150, 9'd150, 16'h0070, 4'd0, 4'd0, 0, 0, 5'd8),
                end_marker(), end_marker(), 9'd100, 1, 15);
        set_row(7, end_marker(), end_marker(), end_marker(), end_marker(), 9'd100, 0, 0);
        // x of 0 wraps the first pixel to 511
        set_row(8, make_obj(3'd7, 9'd0, 9'd99, 16'h0080, 4'd0, 4'd0, 0, 0, 5'd31),
                end_marker(), end_marker(), end_marker(), 9'd100, 0, 15);

        repeat (2) @(posedge clk);
        #1;
        rst = 0;
        step();

        for (int r = 0; r < n_rows; r++) begin
            for (int a = 0; a < (1 << `OBJ_TABLE_AW); a++) begin  // wipe table
                tbl_we   = 1;
                tbl_addr = a;
                tbl_data = end_marker();
                step();
            end
            for (int a = 0; a < 4; a++) begin
                tbl_addr = a;
                tbl_data = test_ent[r][a];
                step();
            end
            tbl_we  = 0;
            vrender = test_vr[r];
            flip    = test_flip[r];
            start   = 1;
            step();
            start    = 0;
            got_done = 0;
            for (int c = 0; c < 3000 && !got_done; c++) begin
                step();
                got_done = done;
            end
            if (!got_done) begin
                $display("timeout: no done pulse from the scanner on row %0d", r);
                timeouts++;
                break;
            end
            for (int p = 0; p < `OBJ_LINE_W; p++) begin
                rd_en   = 1;
                rd_addr = p;
                step();
            end
            rd_en = 0;
            repeat (2) step();
            if (opaque_count != test_opaque[r]) begin
                $display("Error: %0t opaque_count row %0d expected %0d got %0d",
                         $time, r, test_opaque[r], opaque_count);
                tb_errors++;
            end
        end

        $display("rows %0d, pixel mismatches %0d, count mismatches %0d, timeouts %0d",
                 n_rows, chk_errors, tb_errors, timeouts);
        if (chk_errors == 0 && tb_errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/obj_pkg.sv
rtl/obj_table.sv
rtl/obj_tile_match.sv
rtl/obj_scan.sv
rtl/obj_draw.sv
rtl/obj_line_buf.sv
rtl/obj_top.sv
dv/obj_properties.sv
dv/obj_checker.sv
dv/obj_tb.sv
